// ==== verilog/noc_shim_pkg.sv ====
/*
  Shared widths, depths and flit layout for the NoC link shims.
  WORD_WIDTH must divide evenly by SER_FACTOR.
  LINK_CREDITS must equal the receive FIFO depth.
*/
package noc_shim_pkg;

    localparam int WORD_WIDTH   = 128;
    localparam int SER_FACTOR   = 4;
    localparam int FLIT_WIDTH   = WORD_WIDTH / SER_FACTOR;
    localparam int DEST_WIDTH   = 3;
    localparam int TX_DEPTH     = 4;
    localparam int LINK_CREDITS = 4;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [DEST_WIDTH-1:0] dest_t;

    // Tail sits in the lowest bit, destination just above it
    typedef struct packed {
        logic [FLIT_WIDTH-1:0] data;
        dest_t                 dest;
        logic                  tail;
    } flit_t;

    typedef logic [$clog2(SER_FACTOR)-1:0] ser_count_t;

endpackage

// ==== verilog/flit_fifo.sv ====
/*
  Single-clock flit FIFO.
  Writes while full and reads while empty are ignored.
  SHOWAHEAD = 1 presents the head combinationally; SHOWAHEAD = 0
  registers rd_flit on the cycle after rd_en.
*/
module flit_fifo
    import noc_shim_pkg::*;
#(
    parameter int DEPTH     = 4,
    parameter bit SHOWAHEAD = 1'b0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_en,
    input  flit_t wr_flit,
    input  logic  rd_en,
    output flit_t rd_flit,
    output logic  empty,
    output logic  full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_wr;
    logic              do_rd;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    generate
        if (SHOWAHEAD) begin : g_showahead
            assign rd_flit = mem[rd_ptr];
        end else begin : g_registered
            flit_t rd_q;

            // Output register holds the last flit read
            always_ff @(posedge clk) begin
                if (do_rd) begin
                    rd_q <= mem[rd_ptr];
                end
            end

            assign rd_flit = rd_q;
        end
    endgenerate

endmodule

// ==== verilog/axis_serializer.sv ====
/*
  Splits each AXI-Stream word into SER_FACTOR flits, lowest slice first.
  Every flit carries the word's destination; the tail bit is set only
  on the final flit of a word with tlast.
*/
module axis_serializer
    import noc_shim_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  in_tvalid,
    output logic  in_tready,
    input  word_t in_tdata,
    input  dest_t in_tdest,
    input  logic  in_tlast,

    output logic  flit_valid,
    input  logic  flit_ready,
    output flit_t flit
);
    word_t      word_buf;
    dest_t      dest_buf;
    logic       last_buf;
    ser_count_t ser_count;
    logic       last_slice;
    logic       flit_go;

    assign last_slice = (ser_count == ser_count_t'(SER_FACTOR - 1));
    assign flit_go    = flit_valid & flit_ready;

    // Refill when empty or when the final flit of the held word leaves
    assign in_tready = ~flit_valid | (flit_ready & last_slice);

    assign flit.data = word_buf[ser_count * FLIT_WIDTH +: FLIT_WIDTH];
    assign flit.dest = dest_buf;
    assign flit.tail = last_buf & last_slice;

    always_ff @(posedge clk) begin
        if (in_tvalid && in_tready) begin
            word_buf <= in_tdata;
            dest_buf <= in_tdest;
            last_buf <= in_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ser_count  <= '0;
            flit_valid <= 1'b0;
        end else begin
            if (flit_go) begin
                ser_count <= last_slice ? '0 : ser_count + 1'b1;
            end
            if (in_tvalid && in_tready) begin
                flit_valid <= 1'b1;
            end else if (flit_go && last_slice) begin
                flit_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/credit_tx.sv ====
/*
  Credit-based link transmitter.
  Reads the transmit FIFO (no show-ahead) while credits remain; the
  flit shows up on the FIFO output one cycle later, aligned with
  link_send. Credits start at LINK_CREDITS.
*/
module credit_tx
    import noc_shim_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic fifo_empty,
    output logic fifo_rd,
    output logic link_send,
    input  logic link_credit
);
    localparam int CREDIT_W = $clog2(LINK_CREDITS) + 1;

    logic [CREDIT_W-1:0] credit_count;

    assign fifo_rd = (credit_count != '0) & ~fifo_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_count <= CREDIT_W'(LINK_CREDITS);
        end else begin
            case ({link_credit, fifo_rd})
                2'b10:   credit_count <= credit_count + 1'b1;
                2'b01:   credit_count <= credit_count - 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    // Send strobe lines up with the registered FIFO output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_send <= 1'b0;
        end else begin
            link_send <= fifo_rd;
        end
    end

endmodule

// ==== verilog/credit_rx.sv ====
/*
  Credit-based link receiver.
  Buffers incoming flits in a show-ahead FIFO of LINK_CREDITS entries
  and returns one credit in the same cycle a flit is popped.
  The sender must never exceed its credits, so the FIFO cannot overflow.
*/
module credit_rx
    import noc_shim_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  link_send,
    input  flit_t link_flit,
    output logic  link_credit,

    output logic  flit_valid,
    input  logic  flit_ready,
    output flit_t flit
);
    logic rx_empty;
    logic pop;

    assign flit_valid  = ~rx_empty;
    assign pop         = flit_valid & flit_ready;
    assign link_credit = pop;

    flit_fifo #(
        .DEPTH     (LINK_CREDITS),
        .SHOWAHEAD (1'b1)
    ) rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (link_send),
        .wr_flit (link_flit),
        .rd_en   (pop),
        .rd_flit (flit),
        .empty   (rx_empty),
        .full    ()
    );

endmodule

// ==== verilog/axis_deserializer.sv ====
/*
  Gathers SER_FACTOR flits into one AXI-Stream word, lowest slice first.
  Destination and last come from the final flit of each word.
  The assembled word is held until out_tready.
*/
module axis_deserializer
    import noc_shim_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  flit_valid,
    output logic  flit_ready,
    input  flit_t flit,

    output logic  out_tvalid,
    input  logic  out_tready,
    output word_t out_tdata,
    output dest_t out_tdest,
    output logic  out_tlast
);
    word_t      word_buf;
    dest_t      dest_buf;
    logic       last_buf;
    ser_count_t ser_count;
    logic       last_slice;
    logic       flit_go;

    assign last_slice = (ser_count == ser_count_t'(SER_FACTOR - 1));
    assign flit_go    = flit_valid & flit_ready;

    // A complete word blocks new flits until it is taken
    assign flit_ready = ~out_tvalid | out_tready;

    assign out_tdata = word_buf;
    assign out_tdest = dest_buf;
    assign out_tlast = last_buf;

    always_ff @(posedge clk) begin
        if (flit_go) begin
            word_buf[ser_count * FLIT_WIDTH +: FLIT_WIDTH] <= flit.data;
            if (last_slice) begin
                dest_buf <= flit.dest;
                last_buf <= flit.tail;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ser_count  <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (flit_go) begin
                ser_count <= last_slice ? '0 : ser_count + 1'b1;
            end
            if (flit_go && last_slice) begin
                out_tvalid <= 1'b1;
            end else if (out_tready) begin
                out_tvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/noc_link_top.sv ====
/*
  Loopback of a transmit shim and a receive shim over a credit link.
  Single clock and reset; the link itself is wires with no delay.
  Up to TX_DEPTH + LINK_CREDITS flits may be in flight.
*/
module noc_link_top
    import noc_shim_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  in_tvalid,
    output logic  in_tready,
    input  word_t in_tdata,
    input  dest_t in_tdest,
    input  logic  in_tlast,

    output logic  out_tvalid,
    input  logic  out_tready,
    output word_t out_tdata,
    output dest_t out_tdest,
    output logic  out_tlast
);
    logic  ser_valid;
    flit_t ser_flit;
    logic  tx_full;
    logic  tx_empty;
    logic  tx_rd;

    // Link wires
    logic  link_send;
    flit_t link_flit;
    logic  link_credit;

    logic  rx_valid;
    logic  rx_ready;
    flit_t rx_flit;

    axis_serializer ser (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tdata   (in_tdata),
        .in_tdest   (in_tdest),
        .in_tlast   (in_tlast),
        .flit_valid (ser_valid),
        .flit_ready (~tx_full),
        .flit       (ser_flit)
    );

    flit_fifo #(
        .DEPTH     (TX_DEPTH),
        .SHOWAHEAD (1'b0)
    ) tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (ser_valid),
        .wr_flit (ser_flit),
        .rd_en   (tx_rd),
        .rd_flit (link_flit),
        .empty   (tx_empty),
        .full    (tx_full)
    );

    credit_tx ctx (
        .clk         (clk),
        .rst_n       (rst_n),
        .fifo_empty  (tx_empty),
        .fifo_rd     (tx_rd),
        .link_send   (link_send),
        .link_credit (link_credit)
    );

    credit_rx crx (
        .clk         (clk),
        .rst_n       (rst_n),
        .link_send   (link_send),
        .link_flit   (link_flit),
        .link_credit (link_credit),
        .flit_valid  (rx_valid),
        .flit_ready  (rx_ready),
        .flit        (rx_flit)
    );

    axis_deserializer deser (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_valid (rx_valid),
        .flit_ready (rx_ready),
        .flit       (rx_flit),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tdata  (out_tdata),
        .out_tdest  (out_tdest),
        .out_tlast  (out_tlast)
    );

endmodule

// ==== testbench/noc_link_assert.sv ====
/*
  Concurrent checks on the credit transmitter, bound into credit_tx.
  All checks are off while rst_n is low.
*/
module noc_link_assert
    import noc_shim_pkg::*;
(
    input logic                          clk,
    input logic                          rst_n,
    input logic                          fifo_rd,
    input logic                          link_send,
    input logic [$clog2(LINK_CREDITS):0] credit_count
);
    localparam int CREDIT_W = $clog2(LINK_CREDITS) + 1;

    // No read without credit
    rd_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd |-> (credit_count != '0))
        else $error("fifo_rd issued with zero credits");

    send_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd |=> link_send)
        else $error("link_send missing one cycle after fifo_rd");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_count <= CREDIT_W'(LINK_CREDITS))
        else $error("credit count above LINK_CREDITS");

endmodule

bind credit_tx noc_link_assert ctx_checks (
    .clk          (clk),
    .rst_n        (rst_n),
    .fifo_rd      (fifo_rd),
    .link_send    (link_send),
    .credit_count (credit_count)
);

// ==== testbench/tb_noc_link.sv ====
/*
  Testbench for the NoC link loopback.
  Random stimulus from a 32-bit Fibonacci LFSR with a fixed seed.
  A queue model holds every accepted input word until it shows up at the output.
  Runs random traffic, a long output stall, more random traffic, then a drain.
  Stops at the first mismatch.
*/
module tb_noc_link
    import noc_shim_pkg::*;
;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_WORDS      = 400;
    localparam int STALL_AT       = 250;
    localparam int STALL_CYCLES   = 200;
    localparam int MAX_PENDING    = 6;
    localparam int TIMEOUT_CYCLES = NUM_WORDS * 40 + 1000;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_LOW    = 1;
    localparam int MODE_HIGH   = 2;

    typedef struct packed {
        word_t data;
        dest_t dest;
        logic  last;
    } beat_t;

    logic  clk;
    logic  rst_n;
    logic  in_tvalid;
    logic  in_tready;
    word_t in_tdata;
    dest_t in_tdest;
    logic  in_tlast;
    logic  out_tvalid;
    logic  out_tready;
    word_t out_tdata;
    dest_t out_tdest;
    logic  out_tlast;

    logic [31:0] lfsr_state = 32'h03c7_2c86;
    beat_t       model_q[$];
    int          offered;
    int          accepted_count;
    int          delivered_count;
    bit          hold_pending;
    beat_t       hold_beat;

    noc_link_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tdata   (in_tdata),
        .in_tdest   (in_tdest),
        .in_tlast   (in_tlast),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tdata  (out_tdata),
        .out_tdest  (out_tdest),
        .out_tlast  (out_tlast)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [127:0] random_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[126:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_dest(input string name, input dest_t expected, input dest_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // One clock of stimulus; a word waiting for in_tready is held as it is
    task automatic drive_cycle(input int ready_mode);
        logic busy;
        @(posedge clk);
        busy = in_tvalid && !in_tready;
        if (!busy) begin
            if (offered < NUM_WORDS && random_bits(2) != '0) begin
                in_tvalid <= 1'b1;
                in_tdata  <= word_t'(random_bits(WORD_WIDTH));
                in_tdest  <= dest_t'(random_bits(DEST_WIDTH));
                in_tlast  <= (random_bits(1) != '0);
                offered++;
            end else begin
                in_tvalid <= 1'b0;
            end
        end
        case (ready_mode)
            MODE_LOW:  out_tready <= 1'b0;
            MODE_HIGH: out_tready <= 1'b1;
            default:   out_tready <= (random_bits(1) != '0);
        endcase
    endtask

    // Monitor and reference model
    always @(posedge clk) begin
        beat_t expected;
        beat_t got;
        if (rst_n) begin
            if (accepted_count == 0) begin
                check_flag("out_tvalid before first input word", 1'b0, out_tvalid);
            end
            if (in_tvalid && in_tready) begin
                got.data = in_tdata;
                got.dest = in_tdest;
                got.last = in_tlast;
                model_q.push_back(got);
                accepted_count++;
            end
            if (hold_pending) begin
                check_flag("out_tvalid held while waiting", 1'b1, out_tvalid);
                check_word("out_tdata held while waiting", hold_beat.data, out_tdata);
                check_dest("out_tdest held while waiting", hold_beat.dest, out_tdest);
                check_flag("out_tlast held while waiting", hold_beat.last, out_tlast);
            end
            if (out_tvalid && out_tready) begin
                if (model_q.size() == 0) begin
                    abort_run("An output word appeared with no pending input word");
                end
                expected = model_q.pop_front();
                check_word("data order", expected.data, out_tdata);
                check_dest("destination", expected.dest, out_tdest);
                check_flag("last flag", expected.last, out_tlast);
                delivered_count++;
            end
            if (model_q.size() > MAX_PENDING) begin
                abort_run($sformatf("Too many words in flight: %0d", model_q.size()));
            end
            hold_pending = out_tvalid && !out_tready;
            hold_beat.data = out_tdata;
            hold_beat.dest = out_tdest;
            hold_beat.last = out_tlast;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run("Watchdog timeout: the test did not finish in time");
    end

    initial begin
        rst_n      <= 1'b0;
        in_tvalid  <= 1'b0;
        in_tdata   <= '0;
        in_tdest   <= '0;
        in_tlast   <= 1'b0;
        out_tready <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        while (offered < STALL_AT) begin
            drive_cycle(MODE_RANDOM);
        end

        // Output blocked long enough to fill every buffer on the path
        repeat (STALL_CYCLES) drive_cycle(MODE_LOW);
        if (in_tready) begin
            abort_run("in_tready stayed high through the output stall");
        end

        while (offered < NUM_WORDS) begin
            drive_cycle(MODE_RANDOM);
        end
        while (delivered_count < NUM_WORDS) begin
            drive_cycle(MODE_HIGH);
        end
        repeat (20) drive_cycle(MODE_HIGH);

        if (model_q.size() != 0 || delivered_count != NUM_WORDS) begin
            abort_run("Words were left undelivered at the end of the test");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
verilog/noc_shim_pkg.sv
verilog/flit_fifo.sv
verilog/axis_serializer.sv
verilog/credit_tx.sv
verilog/credit_rx.sv
verilog/axis_deserializer.sv
verilog/noc_link_top.sv
testbench/noc_link_assert.sv
testbench/tb_noc_link.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the NoC link testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_noc_link -f sources.f &&
./obj_dir/Vtb_noc_link | tee /dev/stderr | grep -x "No errors" > /dev/null &&
echo "PASS" ||
{
    echo "FAIL"
    exit 1
}
